/* design/armPkg.sv */
package armPkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  regAddr_t;
  typedef logic [3:0]  flags_t;   // N Z C V
  typedef logic [3:0]  cond_t;
  typedef logic [1:0]  aluCtrl_t;
  typedef logic [1:0]  immSrc_t;

  localparam aluCtrl_t aluAdd = 2'b00;
  localparam aluCtrl_t aluSub = 2'b01;
  localparam aluCtrl_t aluAnd = 2'b10;
  localparam aluCtrl_t aluOrr = 2'b11;

  localparam immSrc_t imm8      = 2'b00;  // data processing, zero extended
  localparam immSrc_t imm12     = 2'b01;  // ldr/str offset
  localparam immSrc_t immBranch = 2'b10;  // word offset, sign extended

  // op field, bits 27:26
  localparam logic [1:0] opDataProc = 2'b00;
  localparam logic [1:0] opMemory   = 2'b01;
  localparam logic [1:0] opBranch   = 2'b10;

  // cmd field, bits 24:21
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdOrr = 4'b1100;

  localparam cond_t condEq = 4'b0000;
  localparam cond_t condNe = 4'b0001;
  localparam cond_t condGe = 4'b1010;
  localparam cond_t condLt = 4'b1011;
  localparam cond_t condAl = 4'b1110;

endpackage

/* design/pipePkg.sv */
package pipePkg;

  // operand source picked in execute
  typedef logic [1:0] fwdSel_t;

  localparam fwdSel_t fwdNone = 2'b00;  // register file value
  localparam fwdSel_t fwdWb   = 2'b01;  // result in writeback
  localparam fwdSel_t fwdMem  = 2'b10;  // alu result in memory stage

endpackage

/* design/hazardIf.sv */
`timescale 1ns/100ps

interface hazardIf;
  import armPkg::*;
  import pipePkg::*;

  regAddr_t ra1D, ra2D;
  regAddr_t ra1E, ra2E, wa3E;
  regAddr_t wa3M, wa3W;

  logic regWriteM, regWriteW;
  logic memToRegE;
  logic branchTakenE;

  fwdSel_t forwardAE, forwardBE;
  logic    stallF, stallD;
  logic    flushD, flushE;

  modport dp(output ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
             input forwardAE, forwardBE, stallF, stallD, flushD, flushE);

  modport ctl(output regWriteM, regWriteW, memToRegE, branchTakenE,
              input flushE);

  modport haz(input ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
              input regWriteM, regWriteW, memToRegE, branchTakenE,
              output forwardAE, forwardBE, stallF, stallD, flushD, flushE);

endinterface

/* design/regFile.sv */
`timescale 1ns/100ps

module regFile (
  input  logic             clk,
  input  logic             writeEnable,
  input  armPkg::regAddr_t ra1,
  input  armPkg::regAddr_t ra2,
  input  armPkg::regAddr_t wa3,
  input  armPkg::word_t    wd3,
  input  armPkg::word_t    r15,
  output armPkg::word_t    rd1,
  output armPkg::word_t    rd2
);
  import armPkg::*;

  word_t regs [14:0];

  // written mid-cycle so decode sees the value in the same cycle
  always_ff @(negedge clk) begin
    if (writeEnable && wa3 != 4'hf) begin
      regs[wa3] <= wd3;
    end
  end

  assign rd1 = (ra1 == 4'hf) ? r15 : regs[ra1];
  assign rd2 = (ra2 == 4'hf) ? r15 : regs[ra2];

endmodule

/* design/alu.sv */
`timescale 1ns/100ps

module alu (
  input  armPkg::word_t    a,
  input  armPkg::word_t    b,
  input  armPkg::aluCtrl_t aluControl,
  output armPkg::word_t    result,
  output armPkg::flags_t   flags
);
  import armPkg::*;

  logic        isSub;
  logic        isArith;
  word_t       bInv;
  logic [32:0] sum;

  assign isSub   = (aluControl == aluSub);
  assign isArith = (aluControl == aluAdd) || isSub;

  // subtract as a + ~b + 1
  assign bInv = isSub ? ~b : b;
  assign sum  = {1'b0, a} + {1'b0, bInv} + 33'(isSub);

  always_comb begin
    case (aluControl)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      default: result = sum[31:0];
    endcase
  end

  assign flags[3] = result[31];
  assign flags[2] = (result == '0);
  assign flags[1] = isArith & sum[32];
  // operands agree in sign, sum does not
  assign flags[0] = isArith & ~(a[31] ^ bInv[31]) & (a[31] ^ sum[31]);

endmodule

/* design/controller.sv */
`timescale 1ns/100ps

module controller (
  input  logic              clk,
  input  logic              reset,
  input  armPkg::word_t     instrD,
  input  armPkg::flags_t    aluFlags,
  output logic [1:0]        regSrcD,
  output armPkg::immSrc_t   immSrcD,
  output logic              aluSrcE,
  output armPkg::aluCtrl_t  aluControlE,
  output logic              memWriteM,
  output logic              memToRegW,
  output logic              regWriteW,
  output logic              pcSrcE,
  hazardIf.ctl              hz
);
  import armPkg::*;

  logic [1:0] opD;
  logic [5:0] functD;
  cond_t      condD;

  logic       aluSrcD, regWriteD, memWriteD, memToRegD, branchD;
  aluCtrl_t   aluControlD;
  logic [1:0] flagWriteD;   // [1] nz, [0] cv

  logic       regWriteE, memWriteE, memToRegE, branchE;
  logic [1:0] flagWriteE;
  cond_t      condE;
  logic       condPassE;

  logic       regWriteM, memToRegM;
  flags_t     flags;

  assign opD    = instrD[27:26];
  assign functD = instrD[25:20];
  assign condD  = instrD[31:28];

  always_comb begin
    regSrcD   = 2'b00;
    immSrcD   = imm8;
    aluSrcD   = 1'b0;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD   = 1'b0;
    case (opD)
      opDataProc: begin
        aluSrcD   = functD[5];  // I bit
        regWriteD = 1'b1;
      end
      opMemory: begin
        immSrcD   = imm12;
        aluSrcD   = 1'b1;
        regSrcD   = {~functD[0], 1'b0};  // str reads rd on port 2
        memWriteD = ~functD[0];
        memToRegD = functD[0];
        regWriteD = functD[0];
      end
      opBranch: begin
        immSrcD = immBranch;
        aluSrcD = 1'b1;
        regSrcD = 2'b01;  // base is pc+8
        branchD = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    aluControlD = aluAdd;
    flagWriteD  = 2'b00;
    if (opD == opDataProc) begin
      case (functD[4:1])
        cmdSub:  aluControlD = aluSub;
        cmdAnd:  aluControlD = aluAnd;
        cmdOrr:  aluControlD = aluOrr;
        cmdAdd:  aluControlD = aluAdd;
        default: aluControlD = aluAdd;
      endcase
      flagWriteD[1] = functD[0];
      flagWriteD[0] = functD[0] && (aluControlD == aluAdd || aluControlD == aluSub);
    end
  end

  // decode to execute, bubble on flushE
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      branchE     <= 1'b0;
      flagWriteE  <= 2'b00;
      aluSrcE     <= 1'b0;
      aluControlE <= aluAdd;
      condE       <= condAl;
    end else if (hz.flushE) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memToRegE   <= 1'b0;
      branchE     <= 1'b0;
      flagWriteE  <= 2'b00;
      aluSrcE     <= 1'b0;
      aluControlE <= aluAdd;
      condE       <= condAl;
    end else begin
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      memToRegE   <= memToRegD;
      branchE     <= branchD;
      flagWriteE  <= flagWriteD;
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      condE       <= condD;
    end
  end

  always_comb begin
    case (condE)
      condEq:  condPassE = flags[2];
      condNe:  condPassE = ~flags[2];
      condGe:  condPassE = (flags[3] == flags[0]);
      condLt:  condPassE = (flags[3] != flags[0]);
      condAl:  condPassE = 1'b1;
      default: condPassE = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (flagWriteE[1] && condPassE) flags[3:2] <= aluFlags[3:2];
      if (flagWriteE[0] && condPassE) flags[1:0] <= aluFlags[1:0];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE & condPassE;
      memWriteM <= memWriteE & condPassE;
      memToRegM <= memToRegE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  assign hz.branchTakenE = branchE & condPassE;
  assign hz.memToRegE    = memToRegE;
  assign hz.regWriteM    = regWriteM;
  assign hz.regWriteW    = regWriteW;
  assign pcSrcE          = hz.branchTakenE;

endmodule

/* design/datapath.sv */
`timescale 1ns/100ps

module datapath #(
  parameter armPkg::word_t resetPc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [1:0]       regSrcD,
  input  armPkg::immSrc_t  immSrcD,
  input  logic             aluSrcE,
  input  armPkg::aluCtrl_t aluControlE,
  input  logic             memToRegW,
  input  logic             regWriteW,
  input  logic             pcSrcE,
  output armPkg::word_t    pcF,
  input  armPkg::word_t    instrF,
  output armPkg::word_t    instrD,
  output armPkg::flags_t   aluFlags,
  output armPkg::word_t    aluResultM,
  output armPkg::word_t    writeDataM,
  input  armPkg::word_t    readDataM,
  hazardIf.dp              hz
);
  import armPkg::*;
  import pipePkg::*;

  word_t pcPlus4F, pcNextF;
  word_t rd1D, rd2D, extImmD;
  word_t rd1E, rd2E, extImmE;
  word_t srcAE, srcBE, writeDataE, aluResultE;
  word_t aluOutW, readDataW, resultW;

  function automatic word_t pickOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                        word_t wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      fwdNone: return regVal;
      default: return regVal;
    endcase
  endfunction

  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = pcSrcE ? aluResultE : pcPlus4F;  // branch target from alu

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pcF <= resetPc;
    end else if (!hz.stallF) begin
      pcF <= pcNextF;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD <= '0;
    end else if (hz.flushD) begin
      instrD <= '0;
    end else if (!hz.stallD) begin
      instrD <= instrF;
    end
  end

  assign hz.ra1D = regSrcD[0] ? 4'hf : instrD[19:16];
  assign hz.ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

  // fetch pc+4 is pc+8 of the instruction in decode
  regFile rf (
    .clk        (clk),
    .writeEnable(regWriteW),
    .ra1        (hz.ra1D),
    .ra2        (hz.ra2D),
    .wa3        (hz.wa3W),
    .wd3        (resultW),
    .r15        (pcPlus4F),
    .rd1        (rd1D),
    .rd2        (rd2D)
  );

  always_comb begin
    case (immSrcD)
      imm8:      extImmD = {24'b0, instrD[7:0]};
      imm12:     extImmD = {20'b0, instrD[11:0]};
      immBranch: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      default:   extImmD = '0;
    endcase
  end

  // register numbers feed the hazard unit
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hz.ra1E <= '0;
      hz.ra2E <= '0;
      hz.wa3E <= '0;
      hz.wa3M <= '0;
      hz.wa3W <= '0;
    end else begin
      if (hz.flushE) begin
        hz.ra1E <= '0;
        hz.ra2E <= '0;
        hz.wa3E <= '0;
      end else begin
        hz.ra1E <= hz.ra1D;
        hz.ra2E <= hz.ra2D;
        hz.wa3E <= instrD[15:12];
      end
      hz.wa3M <= hz.wa3E;
      hz.wa3W <= hz.wa3M;
    end
  end

  always_ff @(posedge clk) begin
    rd1E       <= rd1D;
    rd2E       <= rd2D;
    extImmE    <= extImmD;
    aluResultM <= aluResultE;
    writeDataM <= writeDataE;
    aluOutW    <= aluResultM;
    readDataW  <= readDataM;
  end

  assign srcAE      = pickOperand(hz.forwardAE, rd1E, aluResultM, resultW);
  assign writeDataE = pickOperand(hz.forwardBE, rd2E, aluResultM, resultW);
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  alu aluUnit (
    .a         (srcAE),
    .b         (srcBE),
    .aluControl(aluControlE),
    .result    (aluResultE),
    .flags     (aluFlags)
  );

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit (
  hazardIf.haz hz
);
  import armPkg::*;
  import pipePkg::*;

  logic ldrStall;

  // memory stage is younger, so it wins
  function automatic fwdSel_t selectFwd(regAddr_t src, regAddr_t dstM, logic wrM,
                                        regAddr_t dstW, logic wrW);
    if (wrM && src == dstM) begin
      return fwdMem;
    end else if (wrW && src == dstW) begin
      return fwdWb;
    end
    return fwdNone;
  endfunction

  assign hz.forwardAE = selectFwd(hz.ra1E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);
  assign hz.forwardBE = selectFwd(hz.ra2E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);

  // load result not ready until writeback
  assign ldrStall = hz.memToRegE && (hz.ra1D == hz.wa3E || hz.ra2D == hz.wa3E);

  assign hz.stallF = ldrStall;
  assign hz.stallD = ldrStall;
  assign hz.flushD = hz.branchTakenE;
  assign hz.flushE = ldrStall | hz.branchTakenE;  // bubble into execute

endmodule

/* design/armCore.sv */
`timescale 1ns/100ps

module armCore #(
  parameter armPkg::word_t resetPc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          reset,
  input  armPkg::word_t instr,
  input  armPkg::word_t readData,
  output armPkg::word_t pc,
  output logic          memWrite,
  output armPkg::word_t dataAdr,
  output armPkg::word_t writeData
);
  import armPkg::*;

  word_t      instrD;
  flags_t     aluFlags;
  logic [1:0] regSrcD;
  immSrc_t    immSrcD;
  logic       aluSrcE;
  aluCtrl_t   aluControlE;
  logic       memToRegW;
  logic       regWriteW;
  logic       pcSrcE;

  hazardIf hzIf();

  controller ctl (
    .clk        (clk),
    .reset      (reset),
    .instrD     (instrD),
    .aluFlags   (aluFlags),
    .regSrcD    (regSrcD),
    .immSrcD    (immSrcD),
    .aluSrcE    (aluSrcE),
    .aluControlE(aluControlE),
    .memWriteM  (memWrite),
    .memToRegW  (memToRegW),
    .regWriteW  (regWriteW),
    .pcSrcE     (pcSrcE),
    .hz         (hzIf.ctl)
  );

  datapath #(.resetPc(resetPc)) dp (
    .clk        (clk),
    .reset      (reset),
    .regSrcD    (regSrcD),
    .immSrcD    (immSrcD),
    .aluSrcE    (aluSrcE),
    .aluControlE(aluControlE),
    .memToRegW  (memToRegW),
    .regWriteW  (regWriteW),
    .pcSrcE     (pcSrcE),
    .pcF        (pc),
    .instrF     (instr),
    .instrD     (instrD),
    .aluFlags   (aluFlags),
    .aluResultM (dataAdr),
    .writeDataM (writeData),
    .readDataM  (readData),
    .hz         (hzIf.dp)
  );

  hazardUnit hazard (
    .hz(hzIf.haz)
  );

endmodule

/* bench/armCore_props.sv */
`timescale 1ns/100ps

module armCoreProps (
  input logic          clk,
  input logic          reset,
  input logic          memWrite,
  input armPkg::word_t pc
);

  property memWriteKnown;
    @(posedge clk) disable iff (reset)
      !$isunknown(memWrite);
  endproperty

  property pcAligned;
    @(posedge clk) disable iff (reset)
      pc[1:0] == 2'b00;
  endproperty

  // nothing reaches memory before the first store can
  property quietAfterReset;
    @(posedge clk) disable iff (reset)
      $fell(reset) |-> !memWrite ##1 !memWrite ##1 !memWrite;
  endproperty

  memWriteKnownA: assert property (memWriteKnown)
    else $error("memWrite unknown");

  pcAlignedA: assert property (pcAligned)
    else $error("pc not word aligned");

  quietAfterResetA: assert property (quietAfterReset)
    else $error("memWrite high too soon after reset");

endmodule

bind armCore armCoreProps props (
  .clk     (clk),
  .reset   (reset),
  .memWrite(memWrite),
  .pc      (pc)
);

/* bench/armCoreTb.sv */
`timescale 1ns/100ps

module armCoreTb;
  import armPkg::*;

  localparam word_t resetPcTb = 32'h0000_0040;
  localparam word_t haltWord  = {condAl, 4'b1010, 24'hff_fffe};  // b to itself

  logic  clk;
  logic  reset;
  word_t instr, readData, pc, dataAdr, writeData;
  logic  memWrite;

  word_t   prog [$];
  word_t   dmem [0:63];
  word_t   modelMem [0:63];
  word_t   mregs [0:15];
  flags_t  mflags;
  word_t   expAddr [$];
  word_t   expData [$];
  int      storeIdx;
  logic [31:0] lfsrState;

  armCore #(.resetPc(resetPcTb)) DUT (
    .clk(clk), .reset(reset), .instr(instr), .readData(readData),
    .pc(pc), .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData)
  );

  always #4 clk = ~clk;

  task automatic failRun(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic reportMismatch(string name, word_t expected, word_t actual);
    failRun($sformatf("CHECK FAILED at %0t: %s expected %08h got %08h",
                      $time, name, expected, actual));
  endtask

  // taps 32 22 2 1 with one step per bit
  function automatic word_t randBits(int n);
    word_t v;
    logic  nb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      nb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], nb};
      v = {v[30:0], nb};
    end
    return v;
  endfunction

  function automatic word_t fillWord(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t encDp(cond_t c, logic [3:0] cmd, logic s, logic imm,
                                  regAddr_t rn, regAddr_t rd, logic [11:0] op2);
    return {c, 2'b00, imm, cmd, s, rn, rd, op2};
  endfunction

  function automatic word_t encMem(logic ld, regAddr_t rn, regAddr_t rd, logic [11:0] off);
    return {condAl, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, ld, rn, rd, off};
  endfunction

  function automatic logic condHolds(cond_t c, flags_t f);
    case (c)
      condEq:  return f[2];
      condNe:  return !f[2];
      condGe:  return f[3] == f[0];
      condLt:  return f[3] != f[0];
      condAl:  return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic buildProgram();
    word_t a, b, c, d;
    a = randBits(8);
    b = randBits(8);
    c = randBits(8);
    d = randBits(8);
    prog.push_back(encDp(condAl, cmdSub, 0, 0, 15, 0, 12'd15));  // r0 = pc+8 - pc+8
    prog.push_back(encDp(condAl, cmdAdd, 0, 1, 0, 1, {4'h0, a[7:0]}));
    prog.push_back(encDp(condAl, cmdSub, 0, 1, 1, 2, {4'h0, b[7:0]}));
    prog.push_back(encDp(condAl, cmdAnd, 0, 0, 2, 3, 12'd1));
    prog.push_back(encDp(condAl, cmdOrr, 0, 1, 3, 4, {4'h0, c[7:0]}));
    prog.push_back(encDp(condAl, cmdAdd, 0, 0, 4, 5, 12'd2));
    for (int r = 1; r <= 5; r++) begin
      prog.push_back(encMem(0, 0, 4'(r), 12'((r - 1) * 4)));
    end
    // load-use
    prog.push_back(encMem(0, 0, 3, 12'd24));
    prog.push_back(encMem(1, 0, 6, 12'd24));
    prog.push_back(encDp(condAl, cmdAdd, 0, 1, 6, 7, {4'h0, d[7:0]}));
    prog.push_back(encMem(0, 0, 7, 12'd28));
    // r8 equals r1 so eq and ge pass
    for (int r = 10; r <= 13; r++) begin
      prog.push_back(encDp(condAl, cmdAdd, 0, 1, 0, 4'(r), 12'(r * 16)));
    end
    prog.push_back(encDp(condAl, cmdAdd, 0, 1, 0, 8, {4'h0, a[7:0]}));
    prog.push_back(encDp(condAl, cmdSub, 1, 0, 8, 9, 12'd1));
    prog.push_back(encDp(condEq, cmdAdd, 0, 1, 10, 10, 12'd1));
    prog.push_back(encDp(condNe, cmdAdd, 0, 1, 11, 11, 12'd2));
    prog.push_back(encDp(condGe, cmdAdd, 0, 1, 12, 12, 12'd3));
    prog.push_back(encDp(condLt, cmdAdd, 0, 1, 13, 13, 12'd4));
    for (int r = 10; r <= 13; r++) begin
      prog.push_back(encMem(0, 0, 4'(r), 12'(32 + (r - 10) * 4)));
    end
    prog.push_back({condAl, 4'b1010, 24'd1});  // skip next two
    prog.push_back(encMem(0, 0, 1, 12'd200));
    prog.push_back(encMem(0, 0, 2, 12'd204));
    prog.push_back(encMem(0, 0, 9, 12'd48));
    prog.push_back(haltWord);
  endtask

  task automatic runModel();
    int    idx;
    int    steps;
    word_t w, srcA, srcB, res, pc8;
    logic [32:0] wide;
    idx = 0;
    steps = 0;
    mflags = '0;
    for (int r = 0; r < 16; r++) mregs[r] = '0;
    while (idx < prog.size() && prog[idx] != haltWord && steps < 500) begin
      w = prog[idx];
      pc8 = resetPcTb + 32'(idx * 4) + 8;
      mregs[15] = pc8;
      steps++;
      if (!condHolds(w[31:28], mflags)) begin
        idx++;
      end else if (w[27:26] == 2'b10) begin
        idx = idx + 2 + int'($signed(w[23:0]));
      end else if (w[27:26] == 2'b01) begin
        srcA = mregs[w[19:16]] + {20'b0, w[11:0]};
        if (w[20]) begin
          mregs[w[15:12]] = modelMem[srcA[7:2]];
        end else begin
          modelMem[srcA[7:2]] = mregs[w[15:12]];
          expAddr.push_back(srcA);
          expData.push_back(mregs[w[15:12]]);
        end
        idx++;
      end else begin
        srcA = mregs[w[19:16]];
        srcB = w[25] ? {24'b0, w[7:0]} : mregs[w[3:0]];
        wide = '0;
        case (w[24:21])
          cmdSub:  wide = {1'b0, srcA} + {1'b0, ~srcB} + 33'd1;
          cmdAnd:  wide = {1'b0, srcA & srcB};
          cmdOrr:  wide = {1'b0, srcA | srcB};
          default: wide = {1'b0, srcA} + {1'b0, srcB};
        endcase
        res = wide[31:0];
        if (w[20]) begin
          mflags[3] = res[31];
          mflags[2] = (res == 0);
          if (w[24:21] == cmdAdd || w[24:21] == cmdSub) begin
            mflags[1] = wide[32];
            if (w[24:21] == cmdSub) mflags[0] = (srcA[31] != srcB[31]) && (res[31] != srcA[31]);
            else mflags[0] = (srcA[31] == srcB[31]) && (res[31] != srcA[31]);
          end
        end
        mregs[w[15:12]] = res;
        idx++;
      end
    end
  endtask

  initial begin
    clk = 0;
    reset = 1;
    instr = '0;
    readData = '0;
    storeIdx = 0;
    lfsrState = 32'h3802_45b9;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fillWord(32'(i * 4));
      modelMem[i] = dmem[i];
    end
    buildProgram();
    runModel();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 0;
    assert (pc == resetPcTb) else reportMismatch("pc", resetPcTb, pc);
    assert (memWrite == 1'b0) else reportMismatch("memWrite", 0, 32'(memWrite));
    wait (storeIdx == expAddr.size());
    // any stray store still in flight lands within the five stages
    repeat (5) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

  // stores checked and taken while the outputs are settled
  always @(negedge clk) begin
    if (!reset && memWrite) begin
      assert (storeIdx < expAddr.size()) else failRun("store seen beyond the expected list");
      assert (dataAdr == expAddr[storeIdx])
        else reportMismatch("dataAdr", expAddr[storeIdx], dataAdr);
      assert (writeData == expData[storeIdx])
        else reportMismatch("writeData", expData[storeIdx], writeData);
      dmem[dataAdr[7:2]] = writeData;
      storeIdx++;
    end
    if (((pc - resetPcTb) >> 2) < prog.size()) instr <= prog[(pc - resetPcTb) >> 2];
    else instr <= haltWord;
    readData <= dmem[dataAdr[7:2]];
  end

  initial begin
    #1;
    repeat (40 * prog.size() + 5) @(posedge clk);
    failRun($sformatf("timeout: only %0d of %0d stores seen", storeIdx, expAddr.size()));
  end

endmodule

/* all.f */
design/armPkg.sv
design/pipePkg.sv
design/hazardIf.sv
design/regFile.sv
design/alu.sv
design/controller.sv
design/datapath.sv
design/hazardUnit.sv
design/armCore.sv
bench/armCore_props.sv
bench/armCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= armCoreTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f all.f -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
